/* hdl/wiscPkg.sv */
`default_nettype none

package wiscPkg;

  parameter int dataW    = 16;              // datapath and byte-address width
  parameter int memDepth = 1024;            // default memory size in 16-bit words
  parameter int regAddrW = 3;               // eight architectural registers

  // 4-bit opcode field, control group in the upper codes
  typedef enum logic [3:0] {
    opAdd = 4'b0000,                        // rd = rs + rt, sets z n v
    opSub = 4'b0001,                        // rd = rs - rt, sets z n v
    opXor = 4'b0010,                        // rd = rs ^ rt, sets z
    opLw  = 4'b1000,                        // rd = mem[rs + (imm4 << 1)]
    opSw  = 4'b1001,                        // mem[rs + (imm4 << 1)] = rd
    opLlb = 4'b1010,                        // rd = sext(imm8)
    opB   = 4'b1100,                        // pc-relative conditional branch
    opBr  = 4'b1101,                        // register-indirect conditional branch
    opPcs = 4'b1110,                        // rd = pc + 2
    opHlt = 4'b1111                         // stop fetching, pc held
  } opcodeT;

  // branch condition codes, evaluated on {n, v, z}
  typedef enum logic [2:0] {
    condNe     = 3'b000,                    // z clear
    condEq     = 3'b001,                    // z set
    condGt     = 3'b010,                    // z and n clear
    condLt     = 3'b011,                    // n set
    condGe     = 3'b100,                    // z set or greater
    condLe     = 3'b101,                    // n or z set
    condOvf    = 3'b110,                    // v set
    condAlways = 3'b111                     // unconditional
  } condT;

  typedef struct packed {
    logic n;                                // negative
    logic v;                                // signed overflow
    logic z;                                // zero
  } flagsT;

  // register-register and load/store layout, rt doubles as imm4
  // register fields are 4 bits wide, only the low 3 bits select a register
  typedef struct packed {
    opcodeT     op;
    logic [3:0] rd;
    logic [3:0] rs;
    logic [3:0] rt;
  } regFormT;

  typedef struct packed {
    opcodeT     op;
    condT       cond;
    logic [8:0] offset9;                    // signed, in half-words
  } branchFormT;

  typedef struct packed {
    opcodeT     op;
    logic [3:0] rd;
    logic [7:0] imm8;
  } immFormT;

  typedef union packed {
    regFormT    regForm;
    branchFormT branchForm;
    immFormT    immForm;
  } instrU;

endpackage

`default_nettype wire

/* hdl/memBusIf.sv */
`timescale 1ns/10ps
`default_nettype none

// one master's view of the shared memory port
interface memBusIf;
  import wiscPkg::*;

  logic             req;                    // level, held until gnt
  logic             we;                     // 1 = write, 0 = read
  logic [dataW-1:0] addr;                   // byte address
  logic [dataW-1:0] wdata;
  logic             gnt;                    // one-cycle accept pulse
  logic             rdValid;                // pulses one cycle after a read gnt
  logic [dataW-1:0] rdata;                  // valid with rdValid

  modport master (
    output req, we, addr, wdata,
    input  gnt, rdValid, rdata
  );

  modport arbiter (
    input  req, we, addr, wdata,
    output gnt, rdValid, rdata
  );

endinterface

`default_nettype wire

/* hdl/pcControl.sv */
`timescale 1ns/10ps
`default_nettype none

module pcControl (
  input  logic [wiscPkg::dataW-1:0] pcIn,         // current pc
  input  logic [wiscPkg::dataW-1:0] regData,      // rs value, target of BR
  input  wiscPkg::instrU            instr,
  input  wiscPkg::flagsT            flags,
  output logic [wiscPkg::dataW-1:0] pcNext,
  output logic                      branchTaken
);
  import wiscPkg::*;

  opcodeT           op;
  logic [8:0]       offset9;
  logic [dataW-1:0] pcPlus2;                // sequential successor
  logic [dataW-1:0] offsetExt;              // sign-extended, shifted to bytes
  logic [dataW-1:0] pcTarget;               // B target
  logic             willBranch;             // condition met on current flags

  assign op      = instr.branchForm.op;
  assign offset9 = instr.branchForm.offset9;

  assign pcPlus2   = pcIn + dataW'(2);
  assign offsetExt = {{(dataW - 10){offset9[8]}}, offset9, 1'b0};
  assign pcTarget  = pcPlus2 + offsetExt;   // relative to the next instruction

  always_comb begin
    case (instr.branchForm.cond)
      condNe:     willBranch = ~flags.z;
      condEq:     willBranch = flags.z;
      condGt:     willBranch = ~flags.z & ~flags.n;
      condLt:     willBranch = flags.n;
      condGe:     willBranch = flags.z | (~flags.z & ~flags.n);
      condLe:     willBranch = flags.n | flags.z;
      condOvf:    willBranch = flags.v;
      condAlways: willBranch = 1'b1;
      default:    willBranch = 1'b0;
    endcase
  end

  always_comb begin
    case (op)
      opB:     pcNext = branchTaken ? pcTarget : pcPlus2;
      opBr:    pcNext = branchTaken ? regData : pcPlus2;
      opPcs:   pcNext = pcPlus2;            // link value comes from here too
      opHlt:   pcNext = pcIn;               // pc frozen on halt
      default: pcNext = pcPlus2;            // alu, memory and unknown opcodes
    endcase
  end

  // condition result on the two branch opcodes, low elsewhere
  assign branchTaken = (op inside {opB, opBr}) ? willBranch : 1'b0;

endmodule

`default_nettype wire

/* hdl/regFile.sv */
`timescale 1ns/10ps
`default_nettype none

module regFile (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic [wiscPkg::regAddrW-1:0] rdAddrA,
  input  logic [wiscPkg::regAddrW-1:0] rdAddrB,
  input  logic                         wrEn,
  input  logic [wiscPkg::regAddrW-1:0] wrAddr,
  input  logic [wiscPkg::dataW-1:0]    wrData,
  output logic [wiscPkg::dataW-1:0]    rdDataA,
  output logic [wiscPkg::dataW-1:0]    rdDataB
);
  import wiscPkg::*;

  logic [dataW-1:0] regs [2**regAddrW];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < 2**regAddrW; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && (wrAddr != '0)) begin  // r0 never written
      regs[wrAddr] <= wrData;
    end
  end

  // async reads, r0 forced to zero on both ports
  assign rdDataA = (rdAddrA == '0) ? '0 : regs[rdAddrA];
  assign rdDataB = (rdAddrB == '0) ? '0 : regs[rdAddrB];

endmodule

`default_nettype wire

/* hdl/aluFlags.sv */
`timescale 1ns/10ps
`default_nettype none

module aluFlags (
  input  logic                      clk,
  input  logic                      rstN,
  input  logic                      flagEn,      // one-cycle strobe from EXEC
  input  wiscPkg::instrU            instr,
  input  logic [wiscPkg::dataW-1:0] opA,         // rs
  input  logic [wiscPkg::dataW-1:0] opB,         // rt
  output logic [wiscPkg::dataW-1:0] result,
  output wiscPkg::flagsT            flags
);
  import wiscPkg::*;

  opcodeT           op;
  logic [dataW-1:0] sum;
  logic [dataW-1:0] diff;
  logic             ovfAdd;
  logic             ovfSub;
  logic             ovf;
  logic             isZero;

  assign op   = instr.regForm.op;
  assign sum  = opA + opB;
  assign diff = opA - opB;

  // same-sign operands giving an opposite-sign sum
  assign ovfAdd = (opA[dataW-1] == opB[dataW-1]) && (sum[dataW-1] != opA[dataW-1]);
  // mixed signs where the difference flips away from opA
  assign ovfSub = (opA[dataW-1] != opB[dataW-1]) && (diff[dataW-1] != opA[dataW-1]);

  always_comb begin
    case (op)
      opAdd: begin
        result = sum;
        ovf    = ovfAdd;
      end
      opSub: begin
        result = diff;
        ovf    = ovfSub;
      end
      default: begin
        result = opA ^ opB;                 // XOR and don't-care opcodes
        ovf    = 1'b0;
      end
    endcase
  end

  assign isZero = (result == '0);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      flags <= '0;
    end else if (flagEn) begin
      case (op)
        opAdd, opSub: flags <= '{n: result[dataW-1], v: ovf, z: isZero};
        opXor:        flags.z <= isZero;    // n and v keep their value
        default:      flags <= flags;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/cpuCore.sv */
`timescale 1ns/10ps
`default_nettype none

module cpuCore #(
  parameter int memDepth = wiscPkg::memDepth
) (
  input  logic     clk,
  input  logic     rstN,
  input  logic     run,                     // fetch enable
  memBusIf.master  mem,
  output logic     halted
);
  import wiscPkg::*;

  typedef enum logic [2:0] {stFetch, stWait, stExec, stMem, stHalt} stateT;

  // byte addresses wrap at the memory size
  localparam logic [dataW-1:0] addrMask = dataW'(2 * memDepth - 1);

  stateT                state;
  logic [dataW-1:0]     pc;
  logic [dataW-1:0]     pcNext;
  instrU                ir;                 // instruction register
  opcodeT               op;
  logic                 memGranted;         // LW accepted, data pending
  flagsT                flags;
  logic [dataW-1:0]     rdDataA;
  logic [dataW-1:0]     rdDataB;
  logic [dataW-1:0]     aluResult;
  logic [dataW-1:0]     effAddr;
  logic [dataW-1:0]     wrData;
  logic [regAddrW-1:0]  rdAddrB;
  logic                 wrEn;
  logic                 flagEn;
  logic                 execWrite;          // opcodes writing rd at EXEC

  assign op = ir.regForm.op;

  pcControl iPc (
    .pcIn(pc), .regData(rdDataA), .instr(ir), .flags(flags),
    .pcNext(pcNext), .branchTaken()
  );

  regFile iRegs (
    .clk(clk), .rstN(rstN),
    .rdAddrA(ir.regForm.rs[regAddrW-1:0]), .rdAddrB(rdAddrB),
    .wrEn(wrEn), .wrAddr(ir.regForm.rd[regAddrW-1:0]), .wrData(wrData),
    .rdDataA(rdDataA), .rdDataB(rdDataB)
  );

  aluFlags iAlu (
    .clk(clk), .rstN(rstN), .flagEn(flagEn), .instr(ir),
    .opA(rdDataA), .opB(rdDataB), .result(aluResult), .flags(flags)
  );

  assign rdAddrB   = (op == opSw) ? ir.regForm.rd[regAddrW-1:0]   // store data
                                  : ir.regForm.rt[regAddrW-1:0];
  assign execWrite = op inside {opAdd, opSub, opXor, opLlb, opPcs};
  assign flagEn    = (state == stExec) && (op inside {opAdd, opSub, opXor});
  assign wrEn      = ((state == stExec) && execWrite) ||
                     ((state == stMem) && memGranted && mem.rdValid);

  always_comb begin
    case (op)
      opLlb:   wrData = {{(dataW - 8){ir.immForm.imm8[7]}}, ir.immForm.imm8};
      opPcs:   wrData = pcNext;             // pc + 2 for PCS
      opLw:    wrData = mem.rdata;
      default: wrData = aluResult;
    endcase
  end

  // rs + sext(imm4) << 1, regs stay stable until the access completes
  assign effAddr = (rdDataA + {{(dataW - 5){ir.regForm.rt[3]}}, ir.regForm.rt, 1'b0})
                   & addrMask;

  assign mem.req   = ((state == stFetch) && run) || ((state == stMem) && !memGranted);
  assign mem.we    = (state == stMem) && (op == opSw);
  assign mem.addr  = (state == stMem) ? effAddr : (pc & addrMask);
  assign mem.wdata = rdDataB;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state      <= stFetch;
      pc         <= '0;
      memGranted <= 1'b0;
      halted     <= 1'b0;
    end else begin
      case (state)
        stFetch: if (mem.gnt) state <= stWait;
        stWait:  if (mem.rdValid) state <= stExec;
        stExec: begin
          pc <= pcNext;                     // held on HLT
          if (op == opHlt) begin
            state  <= stHalt;
            halted <= 1'b1;
          end else if (op inside {opLw, opSw}) begin
            state <= stMem;
          end else begin
            state <= stFetch;
          end
        end
        stMem: begin
          if (!memGranted) begin
            if (mem.gnt && (op == opSw)) state <= stFetch;
            else if (mem.gnt) memGranted <= 1'b1;
          end else if (mem.rdValid) begin   // load data written this cycle
            memGranted <= 1'b0;
            state      <= stFetch;
          end
        end
        stHalt:  state <= stHalt;           // only reset leaves
        default: state <= stFetch;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == stWait) && mem.rdValid) ir <= mem.rdata;
  end

endmodule

`default_nettype wire

/* hdl/memArbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module memArbiter #(
  parameter int memDepth = wiscPkg::memDepth
) (
  input  logic                          clk,
  input  logic                          rstN,
  memBusIf.arbiter                      core,
  input  logic                          hostReq,
  input  logic                          hostWe,
  input  logic [wiscPkg::dataW-1:0]     hostAddr,     // byte address
  input  logic [wiscPkg::dataW-1:0]     hostWdata,
  output logic                          hostGnt,
  output logic                          hostRdValid,
  output logic [wiscPkg::dataW-1:0]     hostRdata,
  output logic                          memEn,
  output logic                          memWe,
  output logic [$clog2(memDepth)-1:0]   memAddr,      // word address
  output logic [wiscPkg::dataW-1:0]     memWdata,
  input  logic [wiscPkg::dataW-1:0]     memRdata
);
  import wiscPkg::*;

  localparam int memAw = $clog2(memDepth);

  logic [dataW-1:0] selAddr;
  logic             rdValidQ;               // a read was accepted last cycle
  logic             rdSelHost;              // that read belonged to the host

  // host wins every tie, core waits in place
  assign hostGnt  = hostReq;
  assign core.gnt = core.req & ~hostReq;

  assign memEn    = hostReq | core.req;
  assign memWe    = hostReq ? hostWe : core.we;
  assign selAddr  = hostReq ? hostAddr : core.addr;
  assign memAddr  = selAddr[memAw:1];       // drop byte bit
  assign memWdata = hostReq ? hostWdata : core.wdata;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      rdValidQ  <= 1'b0;
      rdSelHost <= 1'b0;
    end else begin
      rdValidQ  <= memEn & ~memWe;
      rdSelHost <= hostReq;
    end
  end

  // route the registered read back to its owner
  assign hostRdValid  = rdValidQ & rdSelHost;
  assign core.rdValid = rdValidQ & ~rdSelHost;
  assign hostRdata    = rdSelHost ? memRdata : '0;
  assign core.rdata   = rdSelHost ? '0 : memRdata;

endmodule

`default_nettype wire

/* hdl/unifiedMem.sv */
`timescale 1ns/10ps
`default_nettype none

module unifiedMem #(
  parameter int memDepth = wiscPkg::memDepth
) (
  input  logic                        clk,
  input  logic                        en,
  input  logic                        we,
  input  logic [$clog2(memDepth)-1:0] addr,     // word address
  input  logic [wiscPkg::dataW-1:0]   wdata,
  output logic [wiscPkg::dataW-1:0]   rdata
);
  import wiscPkg::*;

  logic [dataW-1:0] ram [memDepth];         // instructions and data share it

  // single port, write or registered read per enabled cycle
  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        ram[addr] <= wdata;
      end else begin
        rdata <= ram[addr];                 // seen one cycle after the access
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/wiscTop.sv */
`timescale 1ns/10ps
`default_nettype none

module wiscTop #(
  parameter int memDepth = wiscPkg::memDepth
) (
  input  logic                      clk,
  input  logic                      rstN,
  input  logic                      run,
  input  logic                      hostReq,
  input  logic                      hostWe,
  input  logic [wiscPkg::dataW-1:0] hostAddr,
  input  logic [wiscPkg::dataW-1:0] hostWdata,
  output logic                      hostGnt,
  output logic                      hostRdValid,
  output logic [wiscPkg::dataW-1:0] hostRdata,
  output logic                      halted
);

  logic                        memEn;
  logic                        memWe;
  logic [$clog2(memDepth)-1:0] memAddr;
  logic [wiscPkg::dataW-1:0]   memWdata;
  logic [wiscPkg::dataW-1:0]   memRdata;

  memBusIf coreBus ();                      // core to arbiter

  cpuCore #(.memDepth(memDepth)) iCore (
    .clk(clk), .rstN(rstN), .run(run), .mem(coreBus.master), .halted(halted)
  );

  memArbiter #(.memDepth(memDepth)) iArb (
    .clk(clk), .rstN(rstN), .core(coreBus.arbiter),
    .hostReq(hostReq), .hostWe(hostWe), .hostAddr(hostAddr), .hostWdata(hostWdata),
    .hostGnt(hostGnt), .hostRdValid(hostRdValid), .hostRdata(hostRdata),
    .memEn(memEn), .memWe(memWe), .memAddr(memAddr), .memWdata(memWdata),
    .memRdata(memRdata)
  );

  unifiedMem #(.memDepth(memDepth)) iMem (
    .clk(clk), .en(memEn), .we(memWe), .addr(memAddr), .wdata(memWdata),
    .rdata(memRdata)
  );

endmodule

`default_nettype wire

/* verif/cpuCore_checker.sv */
`timescale 1ns/10ps
`default_nettype none

module cpuCore_checker (
  input logic                      clk,
  input logic                      rstN,
  input logic                      coreReq,
  input logic                      coreGnt,
  input logic                      hostGnt,       // tied low in the core binding
  input logic                      rdGnt,         // read accepted for this master
  input logic                      rdValid,
  input logic                      halted,        // tied low in the arbiter binding
  input logic [wiscPkg::dataW-1:0] pc
);

  int failCnt = 0;                        // failed assertions so far

  // all handshakes and halted quiet once reset has been seen
  assert property (@(posedge clk) !rstN |=> !(coreReq | coreGnt | hostGnt | rdValid | halted))
    else begin
      $error("bus or halted active right after reset");
      failCnt++;
    end

  assert property (@(posedge clk) disable iff (!rstN) !(coreGnt && hostGnt))
    else begin
      $error("grant given to host and core in one cycle");
      failCnt++;
    end

  assert property (@(posedge clk) disable iff (!rstN) coreGnt |-> coreReq)
    else begin
      $error("core granted without a request");
      failCnt++;
    end

  // read data returns exactly one cycle after the grant
  assert property (@(posedge clk) disable iff (!rstN) rdGnt |=> rdValid)
    else begin
      $error("no read valid one cycle after a read grant");
      failCnt++;
    end

  assert property (@(posedge clk) disable iff (!rstN) rdValid |-> $past(rdGnt))
    else begin
      $error("read valid without a read grant the cycle before");
      failCnt++;
    end

  assert property (@(posedge clk) disable iff (!rstN) halted |=> halted && $stable(pc))
    else begin
      $error("halted dropped or pc moved while halted");
      failCnt++;
    end

endmodule

bind cpuCore cpuCore_checker chkCore (
  .clk(clk), .rstN(rstN), .coreReq(mem.req), .coreGnt(mem.gnt), .hostGnt(1'b0),
  .rdGnt(mem.gnt & ~mem.we), .rdValid(mem.rdValid), .halted(halted), .pc(pc)
);

bind memArbiter cpuCore_checker chkArb (
  .clk(clk), .rstN(rstN), .coreReq(core.req), .coreGnt(core.gnt), .hostGnt(hostGnt),
  .rdGnt(hostGnt & ~hostWe), .rdValid(hostRdValid), .halted(1'b0), .pc('0)
);

`default_nettype wire

/* verif/wiscTb.sv */
`timescale 1ns/10ps
`default_nettype none

module wiscTb;
  import wiscPkg::*;

  localparam int memWords   = 1024;
  localparam int regionLo   = 960;        // operands at 960..967, results above
  localparam int gntTimeout = 50;
  localparam int runTimeout = 8000;

  logic        clk;
  logic        rstN;
  logic        run;
  logic        hostReq;
  logic        hostWe;
  logic [15:0] hostAddr;
  logic [15:0] hostWdata;
  logic        hostGnt;
  logic        hostRdValid;
  logic [15:0] hostRdata;
  logic        halted;
  logic [31:0] seed;
  logic [15:0] prog [256];                // program image
  int          progLen;
  logic [15:0] mdl [memWords];            // reference memory

  wiscTop #(.memDepth(memWords)) i_dut (.*);

  initial clk = 1'b0;
  always #4 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s ^= s << 13;
    s ^= s >> 17;
    s ^= s << 5;
    return s;
  endfunction

  function automatic int wordOf(input logic [15:0] addr);
    return (int'(addr) % (2 * memWords)) / 2;  // byte address wraps at memory size
  endfunction

  function automatic logic condMet(input logic [2:0] c, input logic n, v, z);
    case (c)
      3'd0: return !z;
      3'd1: return z;
      3'd2: return !z && !n;
      3'd3: return n;
      3'd4: return z || !n;
      3'd5: return n || z;
      3'd6: return v;
      default: return 1'b1;
    endcase
  endfunction

  function automatic int assertFails();
    return i_dut.iCore.chkCore.failCnt + i_dut.iArb.chkArb.failCnt;
  endfunction

  task automatic abortRun(input string why);
    $display("STATUS: FAIL");
    $fatal(1, "%s", why);
  endtask

  task automatic checkEq(input string name, input logic [15:0] exp, got);
    assert (got === exp) else begin
      $display("error %0t %s expected %h got %h", $time, name, exp, got);
      $display("STATUS: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  always @(negedge clk) if (assertFails() != 0) abortRun("a bound checker assertion failed");

  task automatic emit(input logic [15:0] w);
    prog[progLen] = w;
    progLen++;
  endtask

  function automatic logic [15:0] rForm(input logic [3:0] op, input int rd, rs, rt);
    return {op, 4'(rd), 4'(rs), 4'(rt)};
  endfunction

  // request held from a falling edge until hostGnt shows
  task automatic hostAccess(input int word, input logic we, input logic [15:0] data);
    int waitCnt;
    @(negedge clk);
    hostReq   = 1'b1;
    hostWe    = we;
    hostAddr  = 16'(word * 2);
    hostWdata = data;
    waitCnt   = 0;
    #1;
    while (!hostGnt) begin
      if (waitCnt == gntTimeout) abortRun("timeout, hostGnt never came");
      waitCnt++;
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    hostReq = 1'b0;
  endtask

  task automatic hostRead(input int word);
    hostAccess(word, 1'b0, 16'h0000);
    checkEq("hostRdValid", 16'd1, {15'd0, hostRdValid});  // one cycle after gnt
    checkEq("hostRdata", mdl[word], hostRdata);
  endtask

  task automatic buildProgram();
    int a;
    int b;
    progLen = 0;
    emit({opLlb, 4'd7, 8'h80});           // r7 operand base, word 960
    emit({opLlb, 4'd6, 8'h90});           // r6 result base, word 968
    emit({opLlb, 4'd5, 8'h10});           // result stride of 8 words
    emit(rForm(opLw, 1, 7, 0));
    emit(rForm(opLw, 2, 7, 1));
    emit(rForm(opAdd, 3, 1, 2));
    emit(rForm(opSw, 3, 6, 0));
    emit(rForm(opSub, 3, 1, 2));
    emit(rForm(opSw, 3, 6, 1));
    emit(rForm(opXor, 3, 1, 2));
    emit(rForm(opSw, 3, 6, 2));
    seed = xorshift32(seed);
    emit({opLlb, 4'd3, seed[7:0]});
    emit(rForm(opSw, 3, 6, 3));
    emit(rForm(opAdd, 6, 6, 5));
    // every condition on random, equal and overflowing operands
    for (int t = 0; t < 24; t++) begin
      seed = xorshift32(seed);
      a = (t >= 16) ? 7 : int'(seed[2:0]);
      b = (t >= 16) ? 6 : ((t >= 8) ? a : int'(seed[5:3]));
      emit(rForm(opLw, 1, 7, a));
      emit(rForm(opLw, 2, 7, b));
      emit(rForm(opSub, 3, 1, 2));
      emit({opB, 3'(t % 8), 9'd1});       // skip the marker store when taken
      emit(rForm(opSw, 7, 6, t % 8));
      if (t % 8 == 7) emit(rForm(opAdd, 6, 6, 5));
    end
    // BR to just past its marker store, link kept by SW
    for (int k = 0; k < 4; k += 2) begin
      emit(rForm(opPcs, 4, 0, 0));
      emit(rForm(opSw, 4, 6, k));
      emit({opLlb, 4'd2, 8'd10});
      emit(rForm(opAdd, 4, 4, 2));
      emit({opBr, (k == 0) ? 3'd1 : 3'd2, 1'b0, 4'd4, 4'd0});
      emit(rForm(opSw, 7, 6, k + 1));
    end
    emit({opHlt, 12'h000});
  endtask

  task automatic runModel();
    logic [15:0] r [8];
    logic [15:0] pcM;
    logic [15:0] ins;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] s;
    logic [15:0] ea;
    logic        nf;
    logic        vf;
    logic        zf;
    int          steps;
    for (int i = 0; i < 8; i++) r[i] = '0;
    pcM   = '0;
    nf    = 1'b0;
    vf    = 1'b0;
    zf    = 1'b0;
    steps = 0;
    ins = mdl[wordOf(pcM)];
    while (ins[15:12] != opHlt) begin
      if (steps == 20000) abortRun("reference model never reached HLT");
      steps++;
      a  = r[ins[6:4]];
      b  = r[ins[2:0]];
      ea = a + {{11{ins[3]}}, ins[3:0], 1'b0};
      case (ins[15:12])
        opAdd, opSub: begin
          s  = ins[12] ? a - b : a + b;
          vf = ins[12] ? (a[15] != b[15]) && (s[15] != a[15])
                       : (a[15] == b[15]) && (s[15] != a[15]);
          nf = s[15];
          zf = (s == '0);
          r[ins[10:8]] = s;
        end
        opXor: begin
          s  = a ^ b;
          zf = (s == '0);                 // n and v untouched
          r[ins[10:8]] = s;
        end
        opLw:    r[ins[10:8]] = mdl[wordOf(ea)];
        opSw:    mdl[wordOf(ea)] = r[ins[10:8]];
        opLlb:   r[ins[10:8]] = {{8{ins[7]}}, ins[7:0]};
        opPcs:   r[ins[10:8]] = pcM + 16'd2;
        default: ;
      endcase
      if (ins[15:12] == opB && condMet(ins[11:9], nf, vf, zf))
        pcM = pcM + 16'd2 + {{6{ins[8]}}, ins[8:0], 1'b0};
      else if (ins[15:12] == opBr && condMet(ins[11:9], nf, vf, zf))
        pcM = a;
      else
        pcM = pcM + 16'd2;
      r[0] = '0;
      ins  = mdl[wordOf(pcM)];
    end
  endtask

  initial begin
    int waitCnt;
    rstN      = 1'b0;
    run       = 1'b0;
    hostReq   = 1'b0;
    hostWe    = 1'b0;
    hostAddr  = '0;
    hostWdata = '0;
    seed      = 32'hbeb7b9b8;
    repeat (8) @(negedge clk);
    rstN = 1'b1;
    buildProgram();
    for (int w = 0; w < progLen; w++) begin
      mdl[w] = prog[w];
      hostAccess(w, 1'b1, prog[w]);
    end
    for (int w = regionLo; w < memWords; w++) begin
      seed   = xorshift32(seed);
      mdl[w] = seed[15:0];
      if (w == regionLo + 6) mdl[w] = 16'h0001;  // with 8000 gives signed overflow
      if (w == regionLo + 7) mdl[w] = 16'h8000;
      hostAccess(w, 1'b1, mdl[w]);
    end
    for (int w = regionLo; w < memWords; w++) hostRead(w);
    runModel();
    @(negedge clk);
    run = 1'b1;
    for (int w = regionLo; w < regionLo + 8; w++) hostRead(w);  // races the core
    waitCnt = 0;
    while (!halted) begin
      if (waitCnt == runTimeout) abortRun("timeout, halted never rose");
      waitCnt++;
      @(negedge clk);
    end
    for (int w = regionLo; w < memWords; w++) hostRead(w);
    if (assertFails() == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      abortRun("bound checker reported assertion failures");
    end
  end

endmodule

`default_nettype wire

/* wisc.f */
hdl/wiscPkg.sv
hdl/memBusIf.sv
hdl/pcControl.sv
hdl/regFile.sv
hdl/aluFlags.sv
hdl/cpuCore.sv
hdl/memArbiter.sv
hdl/unifiedMem.sv
hdl/wiscTop.sv
verif/cpuCore_checker.sv
verif/wiscTb.sv
